// File: design/gcm_pkg.sv
package gcm_pkg;

    localparam int BLOCK_W = 128;
    localparam int IV_W    = 96;
    localparam int CTR_W   = 32;

    // Block phase codes as the AES worker stages use them
    typedef enum logic [2:0] {
        PH_TEXT_FIRST    = 3'b000,
        PH_TEXT          = 3'b001,
        PH_AAD           = 3'b010,
        PH_TEXT_LAST     = 3'b011,
        PH_LEN           = 3'b100,
        PH_FIRST_IS_LAST = 3'b111
    } phase_t;

    typedef struct packed {
        logic [BLOCK_W-1:0] data;
    } in_block_t;

    typedef struct packed {
        logic [BLOCK_W-1:0] ctr;
        phase_t             phase;
        logic [BLOCK_W-1:0] data;
    } out_desc_t;

    // Word 0 of each register group is the most significant
    localparam logic [31:0] REG_CTRL    = 32'h00;
    localparam logic [31:0] REG_STATUS  = 32'h04;
    localparam logic [31:0] REG_H0      = 32'h10;
    localparam logic [31:0] REG_H3      = 32'h1C;
    localparam logic [31:0] REG_IV0     = 32'h20;
    localparam logic [31:0] REG_IV2     = 32'h28;
    localparam logic [31:0] REG_AAD_LEN = 32'h30;
    localparam logic [31:0] REG_TXT_LEN = 32'h34;
    localparam logic [31:0] REG_DATA0   = 32'h40;
    localparam logic [31:0] REG_DATA3   = 32'h4C;
    localparam logic [31:0] REG_TAG0    = 32'h50;
    localparam logic [31:0] REG_TAG3    = 32'h5C;

endpackage

// File: design/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_push,
    input  T     i_data,
    output logic o_full,
    input  logic i_pop,
    output T     o_data,
    output logic o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_empty = (count == '0);
    assign do_push = i_push & ~o_full;
    assign do_pop  = i_pop & ~o_empty;
    // Head entry is visible without a read cycle
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= i_data;
    end

endmodule

// File: design/axil_reg_port.sv
`timescale 1ns/1ps

module axil_reg_port #(
    parameter int ADDR_W = 8
) (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic [ADDR_W-1:0]                   i_awaddr,
    input  logic                                i_awvalid,
    output logic                                o_awready,
    input  logic [31:0]                         i_wdata,
    input  logic [3:0]                          i_wstrb,
    input  logic                                i_wvalid,
    output logic                                o_wready,
    output logic [1:0]                          o_bresp,
    output logic                                o_bvalid,
    input  logic                                i_bready,
    input  logic [ADDR_W-1:0]                   i_araddr,
    input  logic                                i_arvalid,
    output logic                                o_arready,
    output logic [31:0]                         o_rdata,
    output logic [1:0]                          o_rresp,
    output logic                                o_rvalid,
    input  logic                                i_rready,
    output logic                                o_start,
    output logic [gcm_pkg::BLOCK_W-1:0]         o_h,
    output logic [gcm_pkg::IV_W-1:0]            o_iv,
    output logic [31:0]                         o_aad_len,
    output logic [31:0]                         o_txt_len,
    output logic                                o_push,
    output gcm_pkg::in_block_t                  o_block,
    input  logic                                i_in_full,
    input  logic [gcm_pkg::BLOCK_W-1:0]         i_tag,
    input  logic                                i_done,
    input  logic                                i_busy
);

    logic [31:0]      wa;
    logic [31:0]      ra;
    logic [31:0]      rd_mux;
    logic             wr_en;
    logic             rd_en;
    logic             done_q;
    logic [0:3][31:0] h_q;
    logic [0:2][31:0] iv_q;
    logic [0:3][31:0] data_q;
    logic [0:3][31:0] tag_q;

    function automatic logic [31:0] merge(input logic [31:0] old_v, input logic [31:0] new_v,
                                          input logic [3:0] strb);
        logic [31:0] res;
        res = old_v;
        for (int b = 0; b < 4; b++)
        begin
            if (strb[b])
                res[8*b +: 8] = new_v[8*b +: 8];
        end
        return res;
    endfunction

    assign wa = 32'(i_awaddr);
    assign ra = 32'(i_araddr);

    // AW and W are taken together; a block push waits for a free FIFO slot
    assign wr_en     = i_awvalid & i_wvalid & ~o_bvalid & ~((wa == gcm_pkg::REG_DATA3) & i_in_full);
    assign o_awready = wr_en;
    assign o_wready  = wr_en;
    assign rd_en     = i_arvalid & ~o_rvalid;
    assign o_arready = rd_en;
    assign o_bresp   = 2'b00;
    assign o_rresp   = 2'b00;

    assign o_h          = h_q;
    assign o_iv         = iv_q;
    assign o_push       = wr_en & (wa == gcm_pkg::REG_DATA3);
    assign o_block.data = {data_q[0], data_q[1], data_q[2], merge(data_q[3], i_wdata, i_wstrb)};

    always_comb
    begin
        rd_mux = '0;
        if (ra == gcm_pkg::REG_STATUS)
            rd_mux = {29'd0, i_in_full, done_q, i_busy};
        else if (ra >= gcm_pkg::REG_H0 && ra <= gcm_pkg::REG_H3)
            rd_mux = h_q[ra[3:2]];
        else if (ra >= gcm_pkg::REG_IV0 && ra <= gcm_pkg::REG_IV2)
            rd_mux = iv_q[ra[3:2]];
        else if (ra == gcm_pkg::REG_AAD_LEN)
            rd_mux = o_aad_len;
        else if (ra == gcm_pkg::REG_TXT_LEN)
            rd_mux = o_txt_len;
        else if (ra >= gcm_pkg::REG_TAG0 && ra <= gcm_pkg::REG_TAG3)
            rd_mux = tag_q[ra[3:2]];
    end

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_bvalid  <= 1'b0;
            o_rvalid  <= 1'b0;
            o_start   <= 1'b0;
            done_q    <= 1'b0;
            h_q       <= '0;
            iv_q      <= '0;
            o_aad_len <= '0;
            o_txt_len <= '0;
        end
        else
        begin
            o_bvalid <= wr_en | (o_bvalid & ~i_bready);
            o_rvalid <= rd_en | (o_rvalid & ~i_rready);
            o_start  <= wr_en & (wa == gcm_pkg::REG_CTRL) & i_wstrb[0] & i_wdata[0];
            // Done holds until the next instance starts
            if (o_start)
                done_q <= 1'b0;
            else if (i_done)
                done_q <= 1'b1;
            if (wr_en)
            begin
                if (wa >= gcm_pkg::REG_H0 && wa <= gcm_pkg::REG_H3)
                    h_q[wa[3:2]] <= merge(h_q[wa[3:2]], i_wdata, i_wstrb);
                else if (wa >= gcm_pkg::REG_IV0 && wa <= gcm_pkg::REG_IV2)
                    iv_q[wa[3:2]] <= merge(iv_q[wa[3:2]], i_wdata, i_wstrb);
                else if (wa == gcm_pkg::REG_AAD_LEN)
                    o_aad_len <= merge(o_aad_len, i_wdata, i_wstrb);
                else if (wa == gcm_pkg::REG_TXT_LEN)
                    o_txt_len <= merge(o_txt_len, i_wdata, i_wstrb);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en && wa >= gcm_pkg::REG_DATA0 && wa <= gcm_pkg::REG_DATA3)
            data_q[wa[3:2]] <= merge(data_q[wa[3:2]], i_wdata, i_wstrb);
        if (i_done)
            tag_q <= i_tag;
        if (rd_en)
            o_rdata <= rd_mux;
    end

endmodule

// File: design/gcm_block_sequencer.sv
`timescale 1ns/1ps

module gcm_block_sequencer (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    input  logic [gcm_pkg::IV_W-1:0]    i_iv,
    input  logic [31:0]                 i_aad_len,
    input  logic [31:0]                 i_txt_len,
    input  logic                        i_in_empty,
    input  gcm_pkg::in_block_t          i_in_data,
    output logic                        o_in_pop,
    input  logic                        i_out_full,
    output logic                        o_out_push,
    output gcm_pkg::out_desc_t          o_out_data,
    input  logic                        i_ghash_ready,
    output logic                        o_ghash_start,
    output logic [gcm_pkg::BLOCK_W-1:0] o_ghash_block,
    output logic                        o_busy
);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_LEN, S_WAIT} state_t;

    state_t                      state;
    logic [gcm_pkg::CTR_W-1:0]   idx;
    logic [gcm_pkg::CTR_W-1:0]   aad_cnt;
    logic [gcm_pkg::CTR_W-1:0]   total_cnt;
    logic [gcm_pkg::CTR_W-1:0]   ctr_val;
    logic [gcm_pkg::BLOCK_W-1:0] len_block;
    logic                        issue_ok;
    logic                        len_go;
    logic                        len_done;
    gcm_pkg::phase_t             phase;

    function automatic logic [127:0] byte_rev(input logic [127:0] d);
        logic [127:0] r;
        for (int n = 0; n < 16; n++)
        begin
            r[8*n +: 8] = d[8*(15-n) +: 8];
        end
        return r;
    endfunction

    // Lengths are in bits and whole blocks, so a shift by seven gives block counts
    assign aad_cnt   = {7'd0, i_aad_len[31:7]};
    assign total_cnt = aad_cnt + {7'd0, i_txt_len[31:7]};
    assign len_block = {32'd0, i_aad_len, 32'd0, i_txt_len};
    // First text block uses counter 2
    assign ctr_val   = idx - aad_cnt + 32'd2;

    // A start still in flight has not yet lowered the GHASH ready
    assign issue_ok = i_ghash_ready & ~o_ghash_start & ~i_out_full & ~i_start;
    assign o_in_pop = (state == S_RUN) & issue_ok & ~i_in_empty;
    assign len_go   = (state == S_LEN) & issue_ok;
    assign len_done = (state == S_WAIT) & i_ghash_ready & ~o_ghash_start;
    assign o_busy   = (state != S_IDLE) & ~len_done;

    always_comb
    begin
        if (idx < aad_cnt)
            phase = gcm_pkg::PH_AAD;
        else if (idx == total_cnt - 1'b1)
            phase = (idx == aad_cnt) ? gcm_pkg::PH_FIRST_IS_LAST : gcm_pkg::PH_TEXT_LAST;
        else if (idx == aad_cnt)
            phase = gcm_pkg::PH_TEXT_FIRST;
        else
            phase = gcm_pkg::PH_TEXT;
    end

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state         <= S_IDLE;
            idx           <= '0;
            o_ghash_start <= 1'b0;
            o_out_push    <= 1'b0;
        end
        else
        begin
            o_ghash_start <= o_in_pop | len_go;
            // AAD blocks only feed the hash
            o_out_push    <= (o_in_pop & (phase != gcm_pkg::PH_AAD)) | len_go;
            if (i_start)
            begin
                idx   <= '0;
                state <= (total_cnt == '0) ? S_LEN : S_RUN;
            end
            else
            begin
                case (state)
                    S_RUN:
                    begin
                        if (o_in_pop)
                        begin
                            idx <= idx + 1'b1;
                            if (idx + 1'b1 == total_cnt)
                                state <= S_LEN;
                        end
                    end
                    S_LEN:
                    begin
                        if (len_go)
                            state <= S_WAIT;
                    end
                    S_WAIT:
                    begin
                        if (len_done)
                            state <= S_IDLE;
                    end
                    default:
                    begin
                        state <= S_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (len_go)
        begin
            o_ghash_block    <= len_block;
            o_out_data.ctr   <= '0;
            o_out_data.phase <= gcm_pkg::PH_LEN;
            o_out_data.data  <= byte_rev(len_block);
        end
        else if (o_in_pop)
        begin
            o_ghash_block    <= i_in_data.data;
            o_out_data.ctr   <= {i_iv, ctr_val};
            o_out_data.phase <= phase;
            o_out_data.data  <= byte_rev(i_in_data.data);
        end
    end

endmodule

// File: design/ghash_engine.sv
`timescale 1ns/1ps

module ghash_engine (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_clear,
    input  logic [gcm_pkg::BLOCK_W-1:0] i_h,
    input  logic                        i_start,
    input  logic [gcm_pkg::BLOCK_W-1:0] i_block,
    output logic                        o_ready,
    output logic [gcm_pkg::BLOCK_W-1:0] o_acc,
    output logic                        o_done
);

    // Bit 0 of the field element is the vector MSB
    localparam logic [gcm_pkg::BLOCK_W-1:0] R_POLY = {8'hE1, 120'd0};

    logic                        busy;
    logic [6:0]                  step;
    logic [gcm_pkg::BLOCK_W-1:0] x_q;
    logic [gcm_pkg::BLOCK_W-1:0] z_q;
    logic [gcm_pkg::BLOCK_W-1:0] v_q;
    logic [gcm_pkg::BLOCK_W-1:0] z_next;
    logic [gcm_pkg::BLOCK_W-1:0] v_next;
    logic                        load;

    assign o_ready = ~busy;
    assign load    = i_start & ~busy & ~i_clear;

    // One multiplier bit per cycle from the top of x_q
    assign z_next = x_q[gcm_pkg::BLOCK_W-1] ? (z_q ^ v_q) : z_q;
    assign v_next = v_q[0] ? ((v_q >> 1) ^ R_POLY) : (v_q >> 1);

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            busy   <= 1'b0;
            step   <= '0;
            o_done <= 1'b0;
            o_acc  <= '0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_clear)
            begin
                busy  <= 1'b0;
                step  <= '0;
                o_acc <= '0;
            end
            else if (load)
            begin
                busy <= 1'b1;
                step <= '0;
            end
            else if (busy)
            begin
                step <= step + 1'b1;
                if (step == 7'd127)
                begin
                    busy   <= 1'b0;
                    o_acc  <= z_next;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            x_q <= o_acc ^ i_block;
            z_q <= '0;
            v_q <= i_h;
        end
        else if (busy)
        begin
            x_q <= x_q << 1;
            z_q <= z_next;
            v_q <= v_next;
        end
    end

endmodule

// File: design/gcm_sched_top.sv
`timescale 1ns/1ps

module gcm_sched_top #(
    parameter int IN_DEPTH  = 4,
    parameter int OUT_DEPTH = 4,
    parameter int ADDR_W    = 8
) (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic [ADDR_W-1:0]           i_awaddr,
    input  logic                        i_awvalid,
    output logic                        o_awready,
    input  logic [31:0]                 i_wdata,
    input  logic [3:0]                  i_wstrb,
    input  logic                        i_wvalid,
    output logic                        o_wready,
    output logic [1:0]                  o_bresp,
    output logic                        o_bvalid,
    input  logic                        i_bready,
    input  logic [ADDR_W-1:0]           i_araddr,
    input  logic                        i_arvalid,
    output logic                        o_arready,
    output logic [31:0]                 o_rdata,
    output logic [1:0]                  o_rresp,
    output logic                        o_rvalid,
    input  logic                        i_rready,
    output logic                        o_desc_valid,
    input  logic                        i_desc_ready,
    output logic [gcm_pkg::BLOCK_W-1:0] o_desc_ctr,
    output gcm_pkg::phase_t             o_desc_phase,
    output logic [gcm_pkg::BLOCK_W-1:0] o_desc_data
);

    logic                        start;
    logic [gcm_pkg::BLOCK_W-1:0] h;
    logic [gcm_pkg::IV_W-1:0]    iv;
    logic [31:0]                 aad_len;
    logic [31:0]                 txt_len;
    logic                        in_push;
    gcm_pkg::in_block_t          in_wr;
    gcm_pkg::in_block_t          in_rd;
    logic                        in_full;
    logic                        in_empty;
    logic                        in_pop;
    logic                        out_push;
    gcm_pkg::out_desc_t          out_wr;
    gcm_pkg::out_desc_t          out_rd;
    logic                        out_full;
    logic                        out_empty;
    logic                        ghash_ready;
    logic                        ghash_start;
    logic [gcm_pkg::BLOCK_W-1:0] ghash_block;
    logic [gcm_pkg::BLOCK_W-1:0] ghash_acc;
    logic                        ghash_done;
    logic                        seq_busy;

    assign o_desc_valid = ~out_empty;
    assign o_desc_ctr   = out_rd.ctr;
    assign o_desc_phase = out_rd.phase;
    assign o_desc_data  = out_rd.data;

    axil_reg_port #(.ADDR_W(ADDR_W)) reg_port_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
        .i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wvalid(i_wvalid), .o_wready(o_wready),
        .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
        .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
        .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
        .o_start(start), .o_h(h), .o_iv(iv), .o_aad_len(aad_len), .o_txt_len(txt_len),
        .o_push(in_push), .o_block(in_wr), .i_in_full(in_full),
        // Only the lengths block hash completes after the sequencer goes idle
        .i_tag(ghash_acc), .i_done(ghash_done & ~seq_busy), .i_busy(seq_busy)
    );

    sync_fifo #(.T(gcm_pkg::in_block_t), .DEPTH(IN_DEPTH)) in_fifo_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_push(in_push), .i_data(in_wr), .o_full(in_full),
        .i_pop(in_pop), .o_data(in_rd), .o_empty(in_empty)
    );

    sync_fifo #(.T(gcm_pkg::out_desc_t), .DEPTH(OUT_DEPTH)) out_fifo_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_push(out_push), .i_data(out_wr), .o_full(out_full),
        .i_pop(o_desc_valid & i_desc_ready), .o_data(out_rd), .o_empty(out_empty)
    );

    gcm_block_sequencer seq_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_start(start), .i_iv(iv), .i_aad_len(aad_len), .i_txt_len(txt_len),
        .i_in_empty(in_empty), .i_in_data(in_rd), .o_in_pop(in_pop),
        .i_out_full(out_full), .o_out_push(out_push), .o_out_data(out_wr),
        .i_ghash_ready(ghash_ready), .o_ghash_start(ghash_start),
        .o_ghash_block(ghash_block), .o_busy(seq_busy)
    );

    ghash_engine ghash_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_clear(start), .i_h(h),
        .i_start(ghash_start), .i_block(ghash_block),
        .o_ready(ghash_ready), .o_acc(ghash_acc), .o_done(ghash_done)
    );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic o_rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset releases just after a rising edge, like any other driven input
    initial
    begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule

// File: verification/tb_gcm_sched.sv
`timescale 1ns/1ps

module tb_gcm_sched;

    // About 29 hash blocks at some 140 cycles each plus the AXI traffic and the stall window,
    // with a wide margin on top
    localparam int MAX_CYCLES = 20000;
    localparam logic [127:0] R_POLY = {8'hE1, 120'd0};

    logic               clk;
    logic               rst_n;
    logic [7:0]         awaddr;
    logic               awvalid;
    logic               awready;
    logic [31:0]        wdata;
    logic [3:0]         wstrb;
    logic               wvalid;
    logic               wready;
    logic [1:0]         bresp;
    logic               bvalid;
    logic               bready;
    logic [7:0]         araddr;
    logic               arvalid;
    logic               arready;
    logic [31:0]        rdata;
    logic [1:0]         rresp;
    logic               rvalid;
    logic               rready;
    logic               desc_valid;
    logic               desc_ready;
    logic [127:0]       desc_ctr;
    gcm_pkg::phase_t    desc_phase;
    logic [127:0]       desc_data;

    int                 cycles = 0;
    logic               hold_ready = 1'b0;
    logic               random_ready = 1'b0;
    logic               held_valid = 1'b0;
    logic               saw_write_stall = 1'b0;
    gcm_pkg::out_desc_t held_desc;
    gcm_pkg::out_desc_t exp_desc;
    gcm_pkg::out_desc_t exp_q[$];
    logic [127:0]       blk_q[$];
    logic [127:0]       cur_h;
    logic [95:0]        cur_iv;
    logic [127:0]       model_tag;

    tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(10)) clock_gen_i (
        .clk(clk), .o_rst_n(rst_n)
    );

    gcm_sched_top #(.IN_DEPTH(4), .OUT_DEPTH(4), .ADDR_W(8)) dut_i (
        .clk(clk), .i_rst_n(rst_n),
        .i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
        .i_wdata(wdata), .i_wstrb(wstrb), .i_wvalid(wvalid), .o_wready(wready),
        .o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready),
        .i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
        .o_rdata(rdata), .o_rresp(rresp), .o_rvalid(rvalid), .i_rready(rready),
        .o_desc_valid(desc_valid), .i_desc_ready(desc_ready),
        .o_desc_ctr(desc_ctr), .o_desc_phase(desc_phase), .o_desc_data(desc_data)
    );

    // GCM field product where vector bit 127 is the x^0 coefficient
    function automatic logic [127:0] gf_mult(input logic [127:0] x, input logic [127:0] y);
        logic [127:0] z;
        logic [127:0] v;
        z = '0;
        v = y;
        for (int i = 0; i < 128; i++)
        begin
            if (x[127 - i])
                z = z ^ v;
            v = v[0] ? ((v >> 1) ^ R_POLY) : (v >> 1);
        end
        return z;
    endfunction

    function automatic logic [127:0] reverse_bytes(input logic [127:0] d);
        logic [127:0] r;
        for (int i = 0; i < 16; i++)
            r[127 - 8*i -: 8] = d[8*i +: 8];
        return r;
    endfunction

    function automatic logic [127:0] random_block();
        logic [127:0] r;
        for (int i = 0; i < 4; i++)
            r[32*i +: 32] = $urandom;
        return r;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp)
        else
            stop_with_error($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        awaddr  = addr[7:0];
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hF;
        wvalid  = 1'b1;
        bready  = 1'b1;
        do
            @(negedge clk);
        while (!awready);
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        assert (bvalid)
        else
            stop_with_error("write response missing one cycle after the write handshake");
        check_value("o_bresp", 128'(bresp), 128'd0);
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        araddr  = addr[7:0];
        arvalid = 1'b1;
        rready  = 1'b1;
        do
            @(negedge clk);
        while (!arready);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        @(negedge clk);
        assert (rvalid)
        else
            stop_with_error("read data missing one cycle after the read handshake");
        check_value("o_rresp", 128'(rresp), 128'd0);
        data = rdata;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // Builds the blocks, the expected descriptors and the model tag, then starts the DUT
    task automatic start_instance(input int n_aad, input int n_txt);
        logic [127:0]       blk;
        logic [127:0]       len_blk;
        gcm_pkg::out_desc_t d;
        cur_h     = random_block();
        blk       = random_block();
        cur_iv    = blk[95:0];
        model_tag = '0;
        blk_q.delete();
        for (int i = 0; i < n_aad + n_txt; i++)
        begin
            blk = random_block();
            blk_q.push_back(blk);
            model_tag = gf_mult(model_tag ^ blk, cur_h);
            if (i >= n_aad)
            begin
                d.ctr  = {cur_iv, 32'(i - n_aad + 2)};
                d.data = reverse_bytes(blk);
                if (n_txt == 1)
                    d.phase = gcm_pkg::PH_FIRST_IS_LAST;
                else if (i == n_aad)
                    d.phase = gcm_pkg::PH_TEXT_FIRST;
                else if (i == n_aad + n_txt - 1)
                    d.phase = gcm_pkg::PH_TEXT_LAST;
                else
                    d.phase = gcm_pkg::PH_TEXT;
                exp_q.push_back(d);
            end
        end
        // Lengths block is len(A) || len(C) with 64 bits each
        len_blk   = {64'(n_aad * 128), 64'(n_txt * 128)};
        model_tag = gf_mult(model_tag ^ len_blk, cur_h);
        d.ctr     = '0;
        d.phase   = gcm_pkg::PH_LEN;
        d.data    = reverse_bytes(len_blk);
        exp_q.push_back(d);
        for (int i = 0; i < 4; i++)
            write_reg(gcm_pkg::REG_H0 + 4*i, cur_h[127 - 32*i -: 32]);
        for (int i = 0; i < 3; i++)
            write_reg(gcm_pkg::REG_IV0 + 4*i, cur_iv[95 - 32*i -: 32]);
        write_reg(gcm_pkg::REG_AAD_LEN, 32'(n_aad * 128));
        write_reg(gcm_pkg::REG_TXT_LEN, 32'(n_txt * 128));
        write_reg(gcm_pkg::REG_CTRL, 32'd1);
    endtask

    task automatic send_blocks();
        logic [127:0] blk;
        for (int i = 0; i < blk_q.size(); i++)
        begin
            blk = blk_q[i];
            for (int w = 0; w < 4; w++)
                write_reg(gcm_pkg::REG_DATA0 + 4*w, blk[127 - 32*w -: 32]);
        end
    endtask

    task automatic finish_instance();
        logic [31:0] status;
        logic [31:0] word;
        status = '0;
        while (!status[1])
            read_reg(gcm_pkg::REG_STATUS, status);
        while (exp_q.size() != 0)
            @(negedge clk);
        read_reg(gcm_pkg::REG_STATUS, status);
        check_value("o_rdata (STATUS)", 128'(status), 128'h2);
        for (int i = 0; i < 4; i++)
        begin
            read_reg(gcm_pkg::REG_TAG0 + 4*i, word);
            check_value($sformatf("o_rdata (TAG%0d)", i), 128'(word),
                        128'(model_tag[127 - 32*i -: 32]));
        end
    endtask

    // Descriptor consumer that is held off, randomly stalling or always ready
    task automatic drive_desc_ready();
        forever
        begin
            @(posedge clk);
            #1;
            if (!rst_n || hold_ready)
                desc_ready = 1'b0;
            else if (random_ready)
                desc_ready = ($urandom % 2) == 0;
            else
                desc_ready = 1'b1;
        end
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
            stop_with_error("timeout, the run exceeded its cycle limit");
    end

    always @(negedge clk)
    begin
        if (rst_n)
        begin
            assert (awready == wready)
            else
                stop_with_error("awready and wready were not raised together");
            assert (!awready || (awvalid && wvalid))
            else
                stop_with_error("a write was accepted without both AW and W valid");
            if (awvalid && wvalid && !awready && !bvalid)
                saw_write_stall <= 1'b1;
        end
    end

    // Stream monitor checks hold stability and the order of the descriptors
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (held_valid)
            begin
                assert (desc_valid)
                else
                    stop_with_error("o_desc_valid dropped before the descriptor was taken");
                check_value("o_desc_ctr", desc_ctr, held_desc.ctr);
                check_value("o_desc_phase", 128'(desc_phase), 128'(held_desc.phase));
                check_value("o_desc_data", desc_data, held_desc.data);
            end
            if (desc_valid && desc_ready)
            begin
                assert (exp_q.size() != 0)
                else
                    stop_with_error("a descriptor arrived when none was expected");
                exp_desc = exp_q.pop_front();
                check_value("o_desc_ctr", desc_ctr, exp_desc.ctr);
                check_value("o_desc_phase", 128'(desc_phase), 128'(exp_desc.phase));
                check_value("o_desc_data", desc_data, exp_desc.data);
            end
            held_valid      <= desc_valid && !desc_ready;
            held_desc.ctr   <= desc_ctr;
            held_desc.phase <= desc_phase;
            held_desc.data  <= desc_data;
        end
    end

    initial
    begin
        logic [31:0] status;
        void'($urandom(9396));
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        desc_ready = 1'b0;
        fork
            drive_desc_ready();
        join_none
        wait (rst_n === 1'b1);
        @(negedge clk);
        assert (!desc_valid && !bvalid && !rvalid)
        else
            stop_with_error("a valid output was active right after reset");
        read_reg(gcm_pkg::REG_STATUS, status);
        check_value("o_rdata (STATUS)", 128'(status), 128'h0);

        // AAD then three text blocks, phases, counters and tag
        start_instance(2, 3);
        send_blocks();
        finish_instance();

        start_instance(1, 1);
        send_blocks();
        finish_instance();

        // Output held off long enough to fill both FIFOs and stall the data port
        hold_ready   = 1'b1;
        random_ready = 1'b1;
        start_instance(2, 10);
        fork
            send_blocks();
            begin
                repeat (1200) @(negedge clk);
                hold_ready = 1'b0;
            end
        join
        finish_instance();
        assert (saw_write_stall)
        else
            stop_with_error("back-pressure never stalled the data write port");
        random_ready = 1'b0;

        // Restart with AAD only, then text only so the counter starts over
        start_instance(3, 0);
        send_blocks();
        finish_instance();

        start_instance(0, 2);
        send_blocks();
        finish_instance();

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: gcm_sched.f
design/gcm_pkg.sv
design/sync_fifo.sv
design/axil_reg_port.sv
design/gcm_block_sequencer.sv
design/ghash_engine.sv
design/gcm_sched_top.sv
verification/tb_clock_gen.sv
verification/tb_gcm_sched.sv
